/* src/renamePkg.sv */
// shared sizes and types for the commit-side rename logic, referenced by scoped name
`default_nettype none

package renamePkg;

  localparam int NUM_LOGICAL     = 32; // architectural registers
  localparam int NUM_PHYS        = 64; // physical registers
  localparam int COMMIT_WIDTH    = 4;  // commit slots and recovery entries per group
  localparam int RECOVER_GROUPS  = 8;  // groups in one full AMT walk
  localparam int RECOVER_CREDITS = 2;  // RMT buffer slots granted after reset

  typedef logic [4:0]  logReg_t;    // logical register index
  typedef logic [5:0]  phyReg_t;    // physical register index
  typedef logic [10:0] amtPacket_t; // upper 5 bits logical and lower 6 bits physical
  typedef logic [6:0]  freeCnt_t;   // free list occupancy 0 to 64
  typedef logic [5:0]  flPtr_t;     // slot index inside the free list ring
  typedef logic [2:0]  recoverGrp_t; // group number during a walk
  typedef logic [1:0]  creditCnt_t;  // credits held toward the RMT

  // recovery sequencer states
  typedef enum logic {
    RS_IDLE, // normal commit operation
    RS_WALK  // streaming the AMT out to the RMT
  } recoverState_t;

endpackage

`default_nettype wire

/* src/amtRam.sv */
// architectural map storage with four async read and four sync write ports, used by archMapTable
`timescale 1ns/1ps
`default_nettype none

module amtRam (
  input  logic               clk,
  input  logic               reset,
  input  renamePkg::logReg_t rdAddr0_i,
  input  renamePkg::logReg_t rdAddr1_i,
  input  renamePkg::logReg_t rdAddr2_i,
  input  renamePkg::logReg_t rdAddr3_i,
  output renamePkg::phyReg_t rdData0_o,
  output renamePkg::phyReg_t rdData1_o,
  output renamePkg::phyReg_t rdData2_o,
  output renamePkg::phyReg_t rdData3_o,
  input  logic               we0_i,
  input  renamePkg::logReg_t wrAddr0_i,
  input  renamePkg::phyReg_t wrData0_i,
  input  logic               we1_i,
  input  renamePkg::logReg_t wrAddr1_i,
  input  renamePkg::phyReg_t wrData1_i,
  input  logic               we2_i,
  input  renamePkg::logReg_t wrAddr2_i,
  input  renamePkg::phyReg_t wrData2_i,
  input  logic               we3_i,
  input  renamePkg::logReg_t wrAddr3_i,
  input  renamePkg::phyReg_t wrData3_i
);

  renamePkg::phyReg_t mapReg [renamePkg::NUM_LOGICAL]; // committed mapping per logical reg

  assign rdData0_o = mapReg[rdAddr0_i]; // reads see the map before this cycle's writes
  assign rdData1_o = mapReg[rdAddr1_i];
  assign rdData2_o = mapReg[rdAddr2_i];
  assign rdData3_o = mapReg[rdAddr3_i];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < renamePkg::NUM_LOGICAL; i++) begin
        mapReg[i] <= renamePkg::phyReg_t'(i); // identity map out of reset
      end
    end else begin
      if (we0_i) mapReg[wrAddr0_i] <= wrData0_i;
      if (we1_i) mapReg[wrAddr1_i] <= wrData1_i;
      if (we2_i) mapReg[wrAddr2_i] <= wrData2_i;
      if (we3_i) mapReg[wrAddr3_i] <= wrData3_i;
    end
  end

  // youngest-writer filtering upstream must leave one writer per entry
  assert property (@(posedge clk) disable iff (reset)
    !((we0_i && we1_i && wrAddr0_i == wrAddr1_i) || (we0_i && we2_i && wrAddr0_i == wrAddr2_i) ||
      (we0_i && we3_i && wrAddr0_i == wrAddr3_i) || (we1_i && we2_i && wrAddr1_i == wrAddr2_i) ||
      (we1_i && we3_i && wrAddr1_i == wrAddr3_i) || (we2_i && we3_i && wrAddr2_i == wrAddr3_i)))
    else $error("amtRam: two enabled write ports share one address");

endmodule

`default_nettype wire

/* src/archMapTable.sv */
// AMT with youngest-writer commit, release selection and a credit-gated recovery walk
`timescale 1ns/1ps
`default_nettype none

module archMapTable (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  commitValid0_i,
  input  renamePkg::amtPacket_t amtPacket0_i,
  input  logic                  commitValid1_i,
  input  renamePkg::amtPacket_t amtPacket1_i,
  input  logic                  commitValid2_i,
  input  renamePkg::amtPacket_t amtPacket2_i,
  input  logic                  commitValid3_i,
  input  renamePkg::amtPacket_t amtPacket3_i,
  input  logic                  recoverFlag_i,   // one-cycle request from the active list
  input  logic                  recoverCredit_i, // RMT consumed one group
  output logic                  releasedValid0_o,
  output renamePkg::phyReg_t    releasedPhyMap0_o,
  output logic                  releasedValid1_o,
  output renamePkg::phyReg_t    releasedPhyMap1_o,
  output logic                  releasedValid2_o,
  output renamePkg::phyReg_t    releasedPhyMap2_o,
  output logic                  releasedValid3_o,
  output renamePkg::phyReg_t    releasedPhyMap3_o,
  output logic                  recoverValid_o,
  output logic                  recoverBusy_o,
  output renamePkg::amtPacket_t recoverPacket0_o,
  output renamePkg::amtPacket_t recoverPacket1_o,
  output renamePkg::amtPacket_t recoverPacket2_o,
  output renamePkg::amtPacket_t recoverPacket3_o
);

  renamePkg::logReg_t       dest0;      // logical destinations of the commit group
  renamePkg::logReg_t       dest1;
  renamePkg::logReg_t       dest2;
  renamePkg::logReg_t       dest3;
  renamePkg::phyReg_t       newPhys0;   // physical regs assigned at rename
  renamePkg::phyReg_t       newPhys1;
  renamePkg::phyReg_t       newPhys2;
  renamePkg::phyReg_t       newPhys3;
  logic                     dontWrite0; // a younger valid slot writes the same reg
  logic                     dontWrite1;
  logic                     dontWrite2;
  renamePkg::logReg_t       rdAddr0;
  renamePkg::logReg_t       rdAddr1;
  renamePkg::logReg_t       rdAddr2;
  renamePkg::logReg_t       rdAddr3;
  renamePkg::phyReg_t       rdData0;
  renamePkg::phyReg_t       rdData1;
  renamePkg::phyReg_t       rdData2;
  renamePkg::phyReg_t       rdData3;
  renamePkg::recoverState_t recoverState;
  renamePkg::recoverGrp_t   groupCnt;   // group being offered to the RMT
  renamePkg::creditCnt_t    creditCnt;  // free RMT buffer slots
  renamePkg::logReg_t       groupBase;  // first logical reg of the current group
  logic                     walking;
  logic                     sendGroup;  // a group leaves this cycle

  assign {dest0, newPhys0} = amtPacket0_i;
  assign {dest1, newPhys1} = amtPacket1_i;
  assign {dest2, newPhys2} = amtPacket2_i;
  assign {dest3, newPhys3} = amtPacket3_i;

  // slot 3 is youngest and always wins
  assign dontWrite0 = (commitValid1_i && dest0 == dest1) || (commitValid2_i && dest0 == dest2) ||
                      (commitValid3_i && dest0 == dest3);
  assign dontWrite1 = (commitValid2_i && dest1 == dest2) || (commitValid3_i && dest1 == dest3);
  assign dontWrite2 = commitValid3_i && dest2 == dest3;

  assign walking   = (recoverState == renamePkg::RS_WALK);
  assign groupBase = renamePkg::logReg_t'(int'(groupCnt) * renamePkg::COMMIT_WIDTH);

  // read ports look up old mappings on commit and sweep the table during a walk
  assign rdAddr0 = walking ? groupBase         : dest0;
  assign rdAddr1 = walking ? groupBase + 5'd1 : dest1;
  assign rdAddr2 = walking ? groupBase + 5'd2 : dest2;
  assign rdAddr3 = walking ? groupBase + 5'd3 : dest3;

  amtRam amtRam0 (
    .clk       (clk),
    .reset     (reset),
    .rdAddr0_i (rdAddr0),
    .rdAddr1_i (rdAddr1),
    .rdAddr2_i (rdAddr2),
    .rdAddr3_i (rdAddr3),
    .rdData0_o (rdData0),
    .rdData1_o (rdData1),
    .rdData2_o (rdData2),
    .rdData3_o (rdData3),
    .we0_i     (commitValid0_i && !dontWrite0),
    .wrAddr0_i (dest0),
    .wrData0_i (newPhys0),
    .we1_i     (commitValid1_i && !dontWrite1),
    .wrAddr1_i (dest1),
    .wrData1_i (newPhys1),
    .we2_i     (commitValid2_i && !dontWrite2),
    .wrAddr2_i (dest2),
    .wrData2_i (newPhys2),
    .we3_i     (commitValid3_i),
    .wrAddr3_i (dest3),
    .wrData3_i (newPhys3)
  );

  // every valid slot frees one reg and a shadowed slot frees its own new one
  assign releasedValid0_o  = commitValid0_i;
  assign releasedPhyMap0_o = dontWrite0 ? newPhys0 : rdData0;
  assign releasedValid1_o  = commitValid1_i;
  assign releasedPhyMap1_o = dontWrite1 ? newPhys1 : rdData1;
  assign releasedValid2_o  = commitValid2_i;
  assign releasedPhyMap2_o = dontWrite2 ? newPhys2 : rdData2;
  assign releasedValid3_o  = commitValid3_i;
  assign releasedPhyMap3_o = rdData3;

  assign sendGroup        = walking && (creditCnt != '0); // stall while the RMT is full
  assign recoverValid_o   = sendGroup;
  assign recoverBusy_o    = walking;
  assign recoverPacket0_o = {rdAddr0, rdData0};
  assign recoverPacket1_o = {rdAddr1, rdData1};
  assign recoverPacket2_o = {rdAddr2, rdData2};
  assign recoverPacket3_o = {rdAddr3, rdData3};

  always_ff @(posedge clk) begin
    if (reset) begin
      recoverState <= renamePkg::RS_IDLE;
      groupCnt     <= '0;
      creditCnt    <= renamePkg::creditCnt_t'(renamePkg::RECOVER_CREDITS);
    end else begin
      creditCnt <= creditCnt + renamePkg::creditCnt_t'(recoverCredit_i)
                             - renamePkg::creditCnt_t'(sendGroup); // returns and spends may overlap
      case (recoverState)
        renamePkg::RS_IDLE: begin
          if (recoverFlag_i) begin
            recoverState <= renamePkg::RS_WALK;
            groupCnt     <= '0;
          end
        end
        renamePkg::RS_WALK: begin
          if (sendGroup) begin
            groupCnt <= groupCnt + 1'b1;
            if (groupCnt == renamePkg::recoverGrp_t'(renamePkg::RECOVER_GROUPS - 1)) begin
              recoverState <= renamePkg::RS_IDLE; // last group just went out
            end
          end
        end
        default: recoverState <= renamePkg::RS_IDLE;
      endcase
    end
  end

  // commit stage must stay quiet while the table is being streamed
  assert property (@(posedge clk) disable iff (reset)
    recoverBusy_o |-> !(commitValid0_i || commitValid1_i || commitValid2_i || commitValid3_i))
    else $error("archMapTable: commit during recovery walk");

  // RMT returns a credit only for a group it actually holds
  assert property (@(posedge clk) disable iff (reset)
    (recoverCredit_i && !sendGroup) |->
      creditCnt < renamePkg::creditCnt_t'(renamePkg::RECOVER_CREDITS))
    else $error("archMapTable: recovery credit above the granted depth");

endmodule

`default_nettype wire

/* src/specFreeList.sv */
// speculative free list ring with four release push ports and one rename pop port
`timescale 1ns/1ps
`default_nettype none

module specFreeList (
  input  logic                clk,
  input  logic                reset,
  input  logic                pushValid0_i, // released regs in slot order
  input  renamePkg::phyReg_t  pushPhys0_i,
  input  logic                pushValid1_i,
  input  renamePkg::phyReg_t  pushPhys1_i,
  input  logic                pushValid2_i,
  input  renamePkg::phyReg_t  pushPhys2_i,
  input  logic                pushValid3_i,
  input  renamePkg::phyReg_t  pushPhys3_i,
  input  logic                allocReq_i,   // rename takes the head this cycle
  output renamePkg::phyReg_t  allocPhys_o,
  output renamePkg::freeCnt_t freeCount_o
);

  renamePkg::phyReg_t  flMem [renamePkg::NUM_PHYS]; // ring of free physical regs
  renamePkg::flPtr_t   headPtr;  // next reg handed to rename
  renamePkg::flPtr_t   tailPtr;  // first empty slot
  renamePkg::freeCnt_t freeCnt;
  renamePkg::flPtr_t   pushOff1; // compacted slot offsets from the tail
  renamePkg::flPtr_t   pushOff2;
  renamePkg::flPtr_t   pushOff3;
  renamePkg::flPtr_t   pushCnt;  // valid pushes this cycle

  // prefix count squeezes out the holes between valid slots
  assign pushOff1 = renamePkg::flPtr_t'(pushValid0_i);
  assign pushOff2 = pushOff1 + renamePkg::flPtr_t'(pushValid1_i);
  assign pushOff3 = pushOff2 + renamePkg::flPtr_t'(pushValid2_i);
  assign pushCnt  = pushOff3 + renamePkg::flPtr_t'(pushValid3_i);

  assign allocPhys_o = flMem[headPtr]; // head is visible before the pop
  assign freeCount_o = freeCnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < renamePkg::NUM_PHYS - renamePkg::NUM_LOGICAL; i++) begin
        flMem[i] <= renamePkg::phyReg_t'(renamePkg::NUM_LOGICAL + i); // regs 32 to 63 start free
      end
    end else begin
      if (pushValid0_i) flMem[tailPtr] <= pushPhys0_i;
      if (pushValid1_i) flMem[tailPtr + pushOff1] <= pushPhys1_i; // pointer wraps at 64
      if (pushValid2_i) flMem[tailPtr + pushOff2] <= pushPhys2_i;
      if (pushValid3_i) flMem[tailPtr + pushOff3] <= pushPhys3_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      headPtr <= '0;
      tailPtr <= renamePkg::flPtr_t'(renamePkg::NUM_PHYS - renamePkg::NUM_LOGICAL);
      freeCnt <= renamePkg::freeCnt_t'(renamePkg::NUM_PHYS - renamePkg::NUM_LOGICAL);
    end else begin
      headPtr <= headPtr + renamePkg::flPtr_t'(allocReq_i);
      tailPtr <= tailPtr + pushCnt;
      freeCnt <= freeCnt + renamePkg::freeCnt_t'(pushCnt)
                         - renamePkg::freeCnt_t'(allocReq_i);
    end
  end

  // releases from the AMT can never hold more than every physical reg
  assert property (@(posedge clk) disable iff (reset)
    (int'(freeCnt) + int'(pushCnt)) <= renamePkg::NUM_PHYS + int'(allocReq_i))
    else $error("specFreeList: push overflows the free list");

  // rename must wait when nothing is free
  assert property (@(posedge clk) disable iff (reset)
    allocReq_i |-> freeCnt != '0)
    else $error("specFreeList: allocation from an empty free list");

endmodule

`default_nettype wire

/* src/renameCommitTop.sv */
// top of the commit-side rename bookkeeping, joins the AMT releases to the free list
`timescale 1ns/1ps
`default_nettype none

module renameCommitTop (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  commitValid0_i,
  input  renamePkg::amtPacket_t amtPacket0_i,
  input  logic                  commitValid1_i,
  input  renamePkg::amtPacket_t amtPacket1_i,
  input  logic                  commitValid2_i,
  input  renamePkg::amtPacket_t amtPacket2_i,
  input  logic                  commitValid3_i,
  input  renamePkg::amtPacket_t amtPacket3_i,
  input  logic                  recoverFlag_i,
  input  logic                  recoverCredit_i,
  output logic                  recoverValid_o,
  output logic                  recoverBusy_o,
  output renamePkg::amtPacket_t recoverPacket0_o,
  output renamePkg::amtPacket_t recoverPacket1_o,
  output renamePkg::amtPacket_t recoverPacket2_o,
  output renamePkg::amtPacket_t recoverPacket3_o,
  input  logic                  allocReq_i,
  output renamePkg::phyReg_t    allocPhys_o,
  output renamePkg::freeCnt_t   freeCount_o,
  output logic                  releasedValid0_o, // releases also feed the free list
  output renamePkg::phyReg_t    releasedPhyMap0_o,
  output logic                  releasedValid1_o,
  output renamePkg::phyReg_t    releasedPhyMap1_o,
  output logic                  releasedValid2_o,
  output renamePkg::phyReg_t    releasedPhyMap2_o,
  output logic                  releasedValid3_o,
  output renamePkg::phyReg_t    releasedPhyMap3_o
);

  archMapTable amt0 (
    .clk (clk), .reset (reset),
    .commitValid0_i (commitValid0_i), .amtPacket0_i (amtPacket0_i),
    .commitValid1_i (commitValid1_i), .amtPacket1_i (amtPacket1_i),
    .commitValid2_i (commitValid2_i), .amtPacket2_i (amtPacket2_i),
    .commitValid3_i (commitValid3_i), .amtPacket3_i (amtPacket3_i),
    .recoverFlag_i (recoverFlag_i), .recoverCredit_i (recoverCredit_i),
    .releasedValid0_o (releasedValid0_o), .releasedPhyMap0_o (releasedPhyMap0_o),
    .releasedValid1_o (releasedValid1_o), .releasedPhyMap1_o (releasedPhyMap1_o),
    .releasedValid2_o (releasedValid2_o), .releasedPhyMap2_o (releasedPhyMap2_o),
    .releasedValid3_o (releasedValid3_o), .releasedPhyMap3_o (releasedPhyMap3_o),
    .recoverValid_o (recoverValid_o), .recoverBusy_o (recoverBusy_o),
    .recoverPacket0_o (recoverPacket0_o), .recoverPacket1_o (recoverPacket1_o),
    .recoverPacket2_o (recoverPacket2_o), .recoverPacket3_o (recoverPacket3_o)
  );

  specFreeList freeList0 (
    .clk (clk), .reset (reset),
    .pushValid0_i (releasedValid0_o), .pushPhys0_i (releasedPhyMap0_o), // written next edge
    .pushValid1_i (releasedValid1_o), .pushPhys1_i (releasedPhyMap1_o),
    .pushValid2_i (releasedValid2_o), .pushPhys2_i (releasedPhyMap2_o),
    .pushValid3_i (releasedValid3_o), .pushPhys3_i (releasedPhyMap3_o),
    .allocReq_i (allocReq_i), .allocPhys_o (allocPhys_o), .freeCount_o (freeCount_o)
  );

endmodule

`default_nettype wire

/* tb/renameCommitTb.sv */
// testbench for renameCommitTop playing rename, active list and RMT against a reference map
`timescale 1ns/1ps
`default_nettype none

module renameCommitTb;

  localparam int CYCLE_LIMIT = 2000; // under 200 cycles of tests plus a wide margin

  logic                  clk;
  logic                  reset;
  logic [3:0]            commitValid;     // one bit per commit slot, slot 0 oldest
  renamePkg::amtPacket_t commitPkt [4];
  logic                  recoverFlag;
  logic                  recoverCredit;
  logic                  allocReq;
  logic                  recoverValid;
  logic                  recoverBusy;
  renamePkg::amtPacket_t recPkt [4];
  renamePkg::phyReg_t    allocPhys;
  renamePkg::freeCnt_t   freeCount;
  logic [3:0]            relValid;
  renamePkg::phyReg_t    relPhys [4];

  renamePkg::phyReg_t    refMap [renamePkg::NUM_LOGICAL]; // expected committed map
  renamePkg::phyReg_t    freeQ [$];        // expected free list contents, head first
  renamePkg::phyReg_t    pending [$];      // allocated and not yet committed
  renamePkg::phyReg_t    expRel [4];
  renamePkg::amtPacket_t expRec [4];
  renamePkg::phyReg_t    expAllocPhys;
  int                    expFreeCount;
  int                    modelCount;       // free count after the cycles seen so far
  logic                  expBusy;
  logic                  walkModel;
  int                    recvGroup;        // groups the RMT has taken in this walk
  int                    outstanding;      // groups held by the RMT without a returned credit
  int                    creditsAvail;
  int                    errCount;
  int                    cycleCnt;

  renameCommitTop dut0 (
    .clk (clk), .reset (reset),
    .commitValid0_i (commitValid[0]), .amtPacket0_i (commitPkt[0]),
    .commitValid1_i (commitValid[1]), .amtPacket1_i (commitPkt[1]),
    .commitValid2_i (commitValid[2]), .amtPacket2_i (commitPkt[2]),
    .commitValid3_i (commitValid[3]), .amtPacket3_i (commitPkt[3]),
    .recoverFlag_i (recoverFlag), .recoverCredit_i (recoverCredit),
    .recoverValid_o (recoverValid), .recoverBusy_o (recoverBusy),
    .recoverPacket0_o (recPkt[0]), .recoverPacket1_o (recPkt[1]),
    .recoverPacket2_o (recPkt[2]), .recoverPacket3_o (recPkt[3]),
    .allocReq_i (allocReq), .allocPhys_o (allocPhys), .freeCount_o (freeCount),
    .releasedValid0_o (relValid[0]), .releasedPhyMap0_o (relPhys[0]),
    .releasedValid1_o (relValid[1]), .releasedPhyMap1_o (relPhys[1]),
    .releasedValid2_o (relValid[2]), .releasedPhyMap2_o (relPhys[2]),
    .releasedValid3_o (relValid[3]), .releasedPhyMap3_o (relPhys[3])
  );

  initial clk = 1'b0;
  always #50 clk = ~clk; // 100 ns period

  always @(posedge clk) begin
    cycleCnt++;
    if (cycleCnt >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  // counts one failed check and prints when it happened
  task automatic flagMismatch(input string msg);
    errCount++;
    $display("** Error %0t: %s", $time, msg);
  endtask

  // reference model steps at the falling edge where inputs and outputs have settled
  always @(negedge clk) begin : refModel
    logic shadowed;
    int   l;
    if (reset) begin
      for (int i = 0; i < renamePkg::NUM_LOGICAL; i++) refMap[i] = renamePkg::phyReg_t'(i);
      freeQ.delete();
      for (int i = renamePkg::NUM_LOGICAL; i < renamePkg::NUM_PHYS; i++) begin
        freeQ.push_back(renamePkg::phyReg_t'(i)); // 32 to 63 free after reset
      end
      modelCount  = renamePkg::NUM_PHYS - renamePkg::NUM_LOGICAL;
      outstanding = 0;
      walkModel   = 1'b0;
      recvGroup   = 0;
    end else begin
      expFreeCount = modelCount; // count the DUT shows during this cycle
      expBusy      = walkModel;
      creditsAvail = renamePkg::RECOVER_CREDITS - outstanding;
      if (allocReq) expAllocPhys = freeQ.pop_front(); // head handed to rename
      for (int k = 0; k < 4; k++) begin // old values are read before the map changes below
        shadowed = 1'b0;
        for (int j = k + 1; j < 4; j++) begin
          if (commitValid[j] && commitPkt[j][10:6] == commitPkt[k][10:6]) shadowed = 1'b1;
        end
        expRel[k] = shadowed ? commitPkt[k][5:0] : refMap[commitPkt[k][10:6]];
      end
      for (int k = 0; k < 4; k++) begin
        if (commitValid[k]) begin
          freeQ.push_back(expRel[k]); // slot order is release order
          refMap[commitPkt[k][10:6]] = commitPkt[k][5:0]; // youngest lands last
          modelCount++;
        end
      end
      if (allocReq) modelCount--;
      outstanding = outstanding + int'(recoverValid) - int'(recoverCredit);
      if (!walkModel && recoverFlag) begin
        walkModel = 1'b1;
        recvGroup = 0;
      end else if (walkModel && recoverValid) begin
        for (int k = 0; k < 4; k++) begin
          l         = recvGroup * renamePkg::COMMIT_WIDTH + k;
          expRec[k] = {renamePkg::logReg_t'(l), refMap[l]};
        end
        if (recvGroup == renamePkg::RECOVER_GROUPS - 1) walkModel = 1'b0; // last group
        recvGroup++;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset) int'(freeCount) == expFreeCount)
    else flagMismatch($sformatf("freeCount_o is %0d, expected %0d",
                                $sampled(freeCount), expFreeCount));

  assert property (@(posedge clk) disable iff (reset) allocReq |-> allocPhys == expAllocPhys)
    else flagMismatch($sformatf("allocPhys_o is %0d, expected %0d",
                                $sampled(allocPhys), expAllocPhys));

  for (genvar k = 0; k < 4; k++) begin : slotChk
    assert property (@(posedge clk) disable iff (reset)
      relValid[k] == commitValid[k] && (!commitValid[k] || relPhys[k] == expRel[k]))
      else flagMismatch($sformatf("slot %0d release %0d, expected %0d",
                                  k, $sampled(relPhys[k]), expRel[k]));
    assert property (@(posedge clk) disable iff (reset) recoverValid |-> recPkt[k] == expRec[k])
      else flagMismatch($sformatf("recovery packet %0d is %h, expected %h",
                                  k, $sampled(recPkt[k]), expRec[k]));
  end

  assert property (@(posedge clk) disable iff (reset) recoverBusy == expBusy)
    else flagMismatch($sformatf("recoverBusy_o is %b, expected %b",
                                $sampled(recoverBusy), expBusy));

  assert property (@(posedge clk) disable iff (reset)
    recoverValid |-> (expBusy && creditsAvail > 0)) // no group without a credit
    else flagMismatch("recovery group sent without a credit");

  assert property (@(posedge clk) disable iff (reset)
    (expBusy && creditsAvail > 0) |-> recoverValid) // resumes as soon as a credit is back
    else flagMismatch("recovery walk stalled while a credit was held");

  assert property (@(posedge clk) disable iff (reset) outstanding <= renamePkg::RECOVER_CREDITS)
    else flagMismatch($sformatf("%0d groups outstanding", outstanding));

  task automatic nextCycle();
    @(posedge clk);
    #1; // inputs change just after the edge
    commitValid   = '0;
    allocReq      = 1'b0;
    recoverFlag   = 1'b0;
    recoverCredit = 1'b0;
  endtask

  task automatic allocRegs(input int n);
    for (int i = 0; i < n; i++) begin
      pending.push_back(allocPhys); // head is valid before the pop
      allocReq = 1'b1;
      nextCycle();
    end
  endtask

  // commits every pending reg and clash mode squeezes destinations into regs 0 to 3
  task automatic commitPending(input bit clash);
    renamePkg::logReg_t d;
    logic [31:0]        used;
    while (pending.size() > 0) begin
      used = '0;
      for (int k = 0; k < 4; k++) begin
        if (pending.size() > 0 && ($urandom % 4) != 0) begin
          d = clash ? renamePkg::logReg_t'($urandom % 4) : renamePkg::logReg_t'($urandom % 32);
          while (!clash && used[d]) d = d + 1'b1; // keep a distinct group distinct
          used[d]        = 1'b1;
          commitValid[k] = 1'b1;
          commitPkt[k]   = {d, pending.pop_front()};
        end
      end
      nextCycle();
    end
  endtask

  // holdCycles of 0 returns credits at once and larger values withhold them for a while
  task automatic recoverWalk(input int holdCycles);
    int held;
    held        = 0;
    recoverFlag = 1'b1;
    nextCycle();
    while (recoverBusy || outstanding > 0) begin
      if (outstanding > 0 && (held >= holdCycles || held == holdCycles / 2)) recoverCredit = 1'b1;
      held++;
      nextCycle();
    end
  endtask

  initial begin
    void'($urandom(32'h780c));
    errCount      = 0;
    cycleCnt      = 0;
    reset         = 1'b1;
    commitValid   = '0;
    allocReq      = 1'b0;
    recoverFlag   = 1'b0;
    recoverCredit = 1'b0;
    expAllocPhys  = '0;
    for (int k = 0; k < 4; k++) begin
      commitPkt[k] = '0;
      expRel[k]    = '0;
      expRec[k]    = '0;
    end
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
    allocRegs(32);      // drains the reset contents 32 to 63
    commitPending(1'b0);
    allocRegs(24);      // released regs come back in release order
    commitPending(1'b1);
    recoverWalk(0);
    allocRegs(16);
    commitPending(1'b1);
    allocRegs(8);
    commitPending(1'b0);
    recoverWalk(8);     // credit starvation
    repeat (3) nextCycle();
    $display("checks done with %0d errors", errCount);
    if (errCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
src/renamePkg.sv
src/amtRam.sv
src/archMapTable.sv
src/specFreeList.sv
src/renameCommitTop.sv
tb/renameCommitTb.sv

/* run.sh */
#!/bin/sh
# compiles the rename commit testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module renameCommitTb \
  -f filelist.f -o simRename
status=0
./obj_dir/simRename > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "sim failed" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation reported a failure"
  exit 1
fi
exit 0
